/* src/prf_types_pkg.sv */
// Physical register file types
// Widths and vector types for register indexes, ROB ids, data and the stored entry

package prf_types_pkg;

    // Physical register count and the index width that follows from it
    localparam int PREG_COUNT = 64;
    localparam int PREG_W = $clog2(PREG_COUNT);

    // Seven ROB entries, the id space rounds up to one spare code
    localparam int ROB_DEPTH = 7;
    localparam int ROB_W = $clog2(ROB_DEPTH + 1);

    // RV32I data width
    localparam int XLEN = 32;

    typedef logic [PREG_W-1:0] preg_idx_t;

    typedef logic [ROB_W-1:0] rob_id_t;

    typedef logic [XLEN-1:0] word_t;

    // One physical register
    // ready is low while a producer is still in flight, and rob_id names that producer
    typedef struct packed {
        word_t   value;
        logic    ready;
        rob_id_t rob_id;
    } prf_entry_t;

endpackage : prf_types_pkg

/* src/cdb_pkg.sv */
// Common data bus and rename allocation records
// Per-lane strobes that the register file receives each cycle

package cdb_pkg;

    // Result broadcast by a functional unit on one bus lane
    typedef struct packed {
        logic                  valid;
        prf_types_pkg::preg_idx_t dest;
        prf_types_pkg::word_t     value;
    } cdb_result_t;

    // Destination register claimed by rename for a newly dispatched instruction
    typedef struct packed {
        logic                     valid;
        prf_types_pkg::preg_idx_t dest;
        prf_types_pkg::rob_id_t   rob_id;
    } rename_alloc_t;

endpackage : cdb_pkg

/* src/prf_entry_array.sv */
// Physical register entry storage
// Applies rename allocations and bus results to the register state each cycle

`timescale 1ns/1ps

module prf_entry_array #(
    parameter int LANES = 2
) (
    input  logic                      clk,
    input  logic                      rst,
    input  cdb_pkg::rename_alloc_t    alloc [LANES],
    input  cdb_pkg::cdb_result_t      cdb [LANES],
    output prf_types_pkg::prf_entry_t entries [prf_types_pkg::PREG_COUNT]
);

    import prf_types_pkg::*;

    // Every register comes out of reset holding zero with no pending producer
    localparam prf_entry_t RESET_ENTRY = '{value: '0, ready: 1'b1, rob_id: '0};

    prf_entry_t entry_q [PREG_COUNT];
    prf_entry_t entry_d [PREG_COUNT];

    // Next state of the whole array
    // Results are applied first so that an allocation to the same register
    // overrides ready and rob_id while the result value still lands
    always_comb begin
        for (int r = 0; r < PREG_COUNT; r++) begin
            entry_d[r] = entry_q[r];
        end

        // Later lanes are applied after earlier ones, so the higher lane wins
        for (int l = 0; l < LANES; l++) begin
            if (cdb[l].valid && cdb[l].dest != '0) begin
                entry_d[cdb[l].dest].value = cdb[l].value;
                entry_d[cdb[l].dest].ready = 1'b1;
            end
        end

        for (int l = 0; l < LANES; l++) begin
            if (alloc[l].valid && alloc[l].dest != '0) begin
                entry_d[alloc[l].dest].ready  = 1'b0;
                entry_d[alloc[l].dest].rob_id = alloc[l].rob_id;
            end
        end

        // Register 0 is hardwired
        entry_d[0] = RESET_ENTRY;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < PREG_COUNT; r++) begin
                entry_q[r] <= RESET_ENTRY;
            end
        end else begin
            for (int r = 0; r < PREG_COUNT; r++) begin
                entry_q[r] <= entry_d[r];
            end
        end
    end

    // The full array is visible to every read port and the tag lookup
    always_comb begin
        for (int r = 0; r < PREG_COUNT; r++) begin
            entries[r] = entry_q[r];
        end
    end

endmodule : prf_entry_array

/* src/prf_bypass_read.sv */
// Single physical register read port
// Forwards a same-cycle bus result and pins register 0 to zero

`timescale 1ns/1ps

module prf_bypass_read #(
    parameter int LANES = 2
) (
    input  prf_types_pkg::preg_idx_t  idx,
    input  prf_types_pkg::prf_entry_t entries [prf_types_pkg::PREG_COUNT],
    input  cdb_pkg::cdb_result_t      cdb [LANES],
    output prf_types_pkg::prf_entry_t rdata
);

    import prf_types_pkg::*;

    localparam prf_entry_t ZERO_ENTRY = '{value: '0, ready: 1'b1, rob_id: '0};

    always_comb begin
        rdata = entries[idx];

        // A result being written this cycle is already final, so take it directly
        // Scanning upward lets the highest matching lane win
        for (int l = 0; l < LANES; l++) begin
            if (cdb[l].valid && cdb[l].dest == idx) begin
                rdata.value = cdb[l].value;
                rdata.ready = 1'b1;
            end
        end

        // Register 0 ignores any bus traffic aimed at it
        if (idx == '0) begin
            rdata = ZERO_ENTRY;
        end
    end

endmodule : prf_bypass_read

/* src/prf_tag_lookup.sv */
// ROB id lookup for bus results
// Reports which ROB entry each bus lane completes, for wakeup and commit

`timescale 1ns/1ps

module prf_tag_lookup #(
    parameter int LANES = 2
) (
    input  cdb_pkg::cdb_result_t      cdb [LANES],
    input  prf_types_pkg::prf_entry_t entries [prf_types_pkg::PREG_COUNT],
    output prf_types_pkg::rob_id_t    rob_id [LANES]
);

    // The producer's rob_id was recorded at allocation and is still held in the entry,
    // since the write from this same result only lands at the next edge
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            if (cdb[l].valid && cdb[l].dest != '0) begin
                rob_id[l] = entries[cdb[l].dest].rob_id;
            end else begin
                rob_id[l] = '0;
            end
        end
    end

endmodule : prf_tag_lookup

/* src/phys_reg_file.sv */
// Physical register file for a two-lane out-of-order RV32I core
// Entry array, bus tag lookup and bypassed dispatch and FU read ports

`timescale 1ns/1ps

module phys_reg_file #(
    parameter int LANES = 2
) (
    input  logic                      clk,
    input  logic                      rst,

    // Rename allocations and bus results, one strobe per lane
    input  cdb_pkg::rename_alloc_t    alloc [LANES],
    input  cdb_pkg::cdb_result_t      cdb [LANES],

    // Source indexes from dispatch and from the functional units
    input  prf_types_pkg::preg_idx_t  disp_rs1_idx [LANES],
    input  prf_types_pkg::preg_idx_t  disp_rs2_idx [LANES],
    input  prf_types_pkg::preg_idx_t  fu_rs1_idx [LANES],
    input  prf_types_pkg::preg_idx_t  fu_rs2_idx [LANES],

    output prf_types_pkg::prf_entry_t disp_rs1 [LANES],
    output prf_types_pkg::prf_entry_t disp_rs2 [LANES],
    output prf_types_pkg::word_t      fu_rs1_val [LANES],
    output prf_types_pkg::word_t      fu_rs2_val [LANES],

    // ROB entry completed by each bus lane
    output prf_types_pkg::rob_id_t    cdb_rob_id [LANES]
);

    import prf_types_pkg::*;

    prf_entry_t entries [PREG_COUNT];

    // FU ports only need the value, the full entry is trimmed below
    prf_entry_t fu_rs1_rd [LANES];
    prf_entry_t fu_rs2_rd [LANES];

    prf_entry_array #(
        .LANES(LANES)
    ) u_entry_array (
        .clk    (clk),
        .rst    (rst),
        .alloc  (alloc),
        .cdb    (cdb),
        .entries(entries)
    );

    prf_tag_lookup #(
        .LANES(LANES)
    ) u_tag_lookup (
        .cdb    (cdb),
        .entries(entries),
        .rob_id (cdb_rob_id)
    );

    // Four read ports per lane
    for (genvar l = 0; l < LANES; l++) begin : g_lane
        prf_bypass_read #(
            .LANES(LANES)
        ) u_disp_rs1 (
            .idx    (disp_rs1_idx[l]),
            .entries(entries),
            .cdb    (cdb),
            .rdata  (disp_rs1[l])
        );

        prf_bypass_read #(
            .LANES(LANES)
        ) u_disp_rs2 (
            .idx    (disp_rs2_idx[l]),
            .entries(entries),
            .cdb    (cdb),
            .rdata  (disp_rs2[l])
        );

        prf_bypass_read #(
            .LANES(LANES)
        ) u_fu_rs1 (
            .idx    (fu_rs1_idx[l]),
            .entries(entries),
            .cdb    (cdb),
            .rdata  (fu_rs1_rd[l])
        );

        prf_bypass_read #(
            .LANES(LANES)
        ) u_fu_rs2 (
            .idx    (fu_rs2_idx[l]),
            .entries(entries),
            .cdb    (cdb),
            .rdata  (fu_rs2_rd[l])
        );

        assign fu_rs1_val[l] = fu_rs1_rd[l].value;
        assign fu_rs2_val[l] = fu_rs2_rd[l].value;
    end

endmodule : phys_reg_file

/* dv/prf_props.sv */
// Physical register update rule assertions
// Bound into the entry array to watch its state after each edge

`timescale 1ns/1ps

module prf_props #(
    parameter int LANES = 2
) (
    input  logic                      clk,
    input  logic                      rst,
    input  cdb_pkg::rename_alloc_t    alloc [LANES],
    input  cdb_pkg::cdb_result_t      cdb [LANES],
    input  prf_types_pkg::prf_entry_t entries [prf_types_pkg::PREG_COUNT]
);

    import prf_types_pkg::*;
    import cdb_pkg::*;

    // Strobes seen at the previous edge, paired with the state they produced
    logic             rst_q;
    rename_alloc_t    alloc_q [LANES];
    cdb_result_t      cdb_q [LANES];
    logic [LANES-1:0] cdb_alloc_hit;

    always_ff @(posedge clk) begin
        rst_q <= rst;
        for (int l = 0; l < LANES; l++) begin
            alloc_q[l] <= alloc[l];
            cdb_q[l] <= cdb[l];
        end
    end

    // A result whose register was also allocated ends busy, so it is excluded below
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            cdb_alloc_hit[l] = 1'b0;
            for (int m = 0; m < LANES; m++) begin
                if (alloc_q[m].valid && alloc_q[m].dest == cdb_q[l].dest) begin
                    cdb_alloc_hit[l] = 1'b1;
                end
            end
        end
    end

    a_zero_reg: assert property (@(posedge clk) disable iff (rst)
        entries[0].value == '0 && entries[0].ready && entries[0].rob_id == '0)
        else $error("physical register 0 left its zero ready state");

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        a_alloc_busy: assert property (@(posedge clk) disable iff (rst)
            (!rst_q && alloc_q[l].valid && alloc_q[l].dest != '0)
            |-> !entries[alloc_q[l].dest].ready)
            else $error("allocation on lane %0d did not clear ready", l);

        a_cdb_ready: assert property (@(posedge clk) disable iff (rst)
            (!rst_q && cdb_q[l].valid && cdb_q[l].dest != '0 && !cdb_alloc_hit[l])
            |-> entries[cdb_q[l].dest].ready)
            else $error("result on lane %0d did not set ready", l);
    end

endmodule : prf_props

bind prf_entry_array prf_props #(
    .LANES(LANES)
) u_props (
    .clk    (clk),
    .rst    (rst),
    .alloc  (alloc),
    .cdb    (cdb),
    .entries(entries)
);

/* dv/prf_tb.sv */
// Physical register file testbench
// Table-driven stimulus checked against a reference model of the register state

`timescale 1ns/1ps

module prf_tb;

    import prf_types_pkg::*;
    import cdb_pkg::*;

    localparam int LANES = 2;
    localparam int MAX_STEPS = 128;
    localparam int RANDOM_STEPS = 64;

    // Read index rows are disp_rs1, disp_rs2, fu_rs1 and fu_rs2 in that order
    typedef struct packed {
        rename_alloc_t [LANES-1:0]       alloc;
        cdb_result_t [LANES-1:0]         cdb;
        preg_idx_t [3:0][LANES-1:0]      rd_idx;
        prf_entry_t [1:0][LANES-1:0]     exp_disp;
        word_t [1:0][LANES-1:0]          exp_fu;
        rob_id_t [LANES-1:0]             exp_rob;
    } step_t;

    logic clk = 1'b0;
    logic rst;

    rename_alloc_t alloc [LANES];
    cdb_result_t   cdb [LANES];
    preg_idx_t     disp_rs1_idx [LANES];
    preg_idx_t     disp_rs2_idx [LANES];
    preg_idx_t     fu_rs1_idx [LANES];
    preg_idx_t     fu_rs2_idx [LANES];
    prf_entry_t    disp_rs1 [LANES];
    prf_entry_t    disp_rs2 [LANES];
    word_t         fu_rs1_val [LANES];
    word_t         fu_rs2_val [LANES];
    rob_id_t       cdb_rob_id [LANES];

    step_t  steps [MAX_STEPS];
    string  step_names [MAX_STEPS];
    step_t  stp;
    int     n_steps = 0;
    int     error_count = 0;
    int     cycle_count = 0;
    integer seed = 32'h8d806568;

    // Reference copy of the register state
    word_t   ref_value [PREG_COUNT];
    logic    ref_ready [PREG_COUNT];
    rob_id_t ref_rob [PREG_COUNT];

    phys_reg_file #(
        .LANES(LANES)
    ) UUT (
        .clk         (clk),
        .rst         (rst),
        .alloc       (alloc),
        .cdb         (cdb),
        .disp_rs1_idx(disp_rs1_idx),
        .disp_rs2_idx(disp_rs2_idx),
        .fu_rs1_idx  (fu_rs1_idx),
        .fu_rs2_idx  (fu_rs2_idx),
        .disp_rs1    (disp_rs1),
        .disp_rs2    (disp_rs2),
        .fu_rs1_val  (fu_rs1_val),
        .fu_rs2_val  (fu_rs2_val),
        .cdb_rob_id  (cdb_rob_id)
    );

    always #4 clk = ~clk;

    // Guards against a stalled run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > n_steps + 20) begin
            $display("ERROR: the run went past %0d cycles without finishing", n_steps + 20);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic clear_step();
        stp = '0;
    endtask

    task automatic push_step(string name);
        steps[n_steps] = stp;
        step_names[n_steps] = name;
        n_steps++;
    endtask

    task automatic set_alloc(int lane, preg_idx_t dest, rob_id_t rob);
        stp.alloc[lane] = '{valid: 1'b1, dest: dest, rob_id: rob};
    endtask

    task automatic set_cdb(int lane, preg_idx_t dest, word_t value);
        stp.cdb[lane] = '{valid: 1'b1, dest: dest, value: value};
    endtask

    task automatic set_reads(int lane, preg_idx_t d1, preg_idx_t d2, preg_idx_t f1,
                             preg_idx_t f2);
        stp.rd_idx[0][lane] = d1;
        stp.rd_idx[1][lane] = d2;
        stp.rd_idx[2][lane] = f1;
        stp.rd_idx[3][lane] = f2;
    endtask

    task automatic build_directed();
        clear_step();
        set_reads(0, 6'd0, 6'd1, 6'd2, 6'd63);
        set_reads(1, 6'd7, 6'd31, 6'd32, 6'd15);
        push_step("reset_state");

        // Two producers claim registers 5 and 9
        clear_step();
        set_alloc(0, 6'd5, 3'd3);
        set_alloc(1, 6'd9, 3'd6);
        set_reads(0, 6'd5, 6'd9, 6'd5, 6'd9);
        push_step("alloc_pair");

        clear_step();
        set_reads(0, 6'd5, 6'd9, 6'd5, 6'd9);
        set_reads(1, 6'd9, 6'd5, 6'd9, 6'd5);
        push_step("alloc_not_ready");

        // Lane 0 is idle but still carries a stale destination that has a pending producer
        // Lane 1 completes register 5, read on the same cycle
        clear_step();
        stp.cdb[0] = '{valid: 1'b0, dest: 6'd9, value: 32'h5555_0009};
        set_cdb(1, 6'd5, 32'hcafe_0005);
        set_reads(0, 6'd5, 6'd9, 6'd5, 6'd9);
        set_reads(1, 6'd5, 6'd5, 6'd9, 6'd5);
        push_step("cdb_bypass");

        clear_step();
        set_cdb(0, 6'd9, 32'h1234_5678);
        set_reads(0, 6'd9, 6'd5, 6'd9, 6'd5);
        push_step("cdb_lane0_write");

        clear_step();
        set_reads(0, 6'd5, 6'd9, 6'd5, 6'd9);
        set_reads(1, 6'd9, 6'd5, 6'd9, 6'd5);
        push_step("results_ready");

        // Register 0 must ignore both kinds of write
        clear_step();
        set_alloc(0, 6'd0, 3'd5);
        set_cdb(1, 6'd0, 32'hdead_beef);
        set_reads(0, 6'd0, 6'd0, 6'd0, 6'd0);
        set_reads(1, 6'd0, 6'd5, 6'd0, 6'd9);
        push_step("zero_reg_write");

        clear_step();
        set_reads(0, 6'd0, 6'd0, 6'd0, 6'd0);
        push_step("zero_reg_after");

        clear_step();
        set_alloc(0, 6'd12, 3'd1);
        set_alloc(1, 6'd12, 3'd4);
        push_step("alloc_same_dest");

        clear_step();
        set_cdb(0, 6'd12, 32'haaaa_0000);
        set_cdb(1, 6'd12, 32'hbbbb_1111);
        set_reads(0, 6'd12, 6'd12, 6'd12, 6'd12);
        set_reads(1, 6'd12, 6'd5, 6'd12, 6'd9);
        push_step("cdb_same_dest");

        clear_step();
        set_reads(0, 6'd12, 6'd12, 6'd12, 6'd12);
        push_step("cdb_same_dest_after");

        clear_step();
        set_alloc(0, 6'd20, 3'd7);
        push_step("alloc_reg20");

        // The old producer completes while rename hands the register out again
        clear_step();
        set_cdb(0, 6'd20, 32'h0bad_f00d);
        set_alloc(1, 6'd20, 3'd2);
        set_reads(0, 6'd20, 6'd20, 6'd20, 6'd20);
        push_step("alloc_and_cdb");

        clear_step();
        set_reads(0, 6'd20, 6'd12, 6'd20, 6'd12);
        set_reads(1, 6'd20, 6'd20, 6'd20, 6'd20);
        push_step("alloc_and_cdb_after");
    endtask

    // Destinations stay within 0 to 15 so that lanes collide often
    task automatic build_random();
        logic [31:0] r;
        for (int i = 0; i < RANDOM_STEPS; i++) begin
            clear_step();
            for (int l = 0; l < LANES; l++) begin
                r = $random(seed);
                stp.alloc[l].valid = r[0];
                stp.alloc[l].dest = {2'b00, r[7:4]};
                stp.alloc[l].rob_id = r[10:8];
                stp.cdb[l].valid = r[1];
                stp.cdb[l].dest = {2'b00, r[15:12]};
                stp.cdb[l].value = $random(seed);
                r = $random(seed);
                for (int k = 0; k < 4; k++) begin
                    stp.rd_idx[k][l] = {2'b00, r[4*k +: 4]};
                end
            end
            push_step($sformatf("random_%0d", i));
        end
    endtask

    function automatic prf_entry_t ref_read(preg_idx_t idx, step_t s);
        prf_entry_t e;
        logic       found;
        found = 1'b0;
        if (idx == '0) begin
            e = '{value: '0, ready: 1'b1, rob_id: '0};
        end else begin
            e = '{value: ref_value[idx], ready: ref_ready[idx], rob_id: ref_rob[idx]};
            for (int l = LANES - 1; l >= 0; l--) begin
                if (!found && s.cdb[l].valid && s.cdb[l].dest == idx) begin
                    e.value = s.cdb[l].value;
                    e.ready = 1'b1;
                    found = 1'b1;
                end
            end
        end
        return e;
    endfunction

    // Results land first, then allocations take ready and rob_id
    task automatic ref_update(step_t s);
        for (int l = 0; l < LANES; l++) begin
            if (s.cdb[l].valid && s.cdb[l].dest != '0) begin
                ref_value[s.cdb[l].dest] = s.cdb[l].value;
                ref_ready[s.cdb[l].dest] = 1'b1;
            end
        end
        for (int l = 0; l < LANES; l++) begin
            if (s.alloc[l].valid && s.alloc[l].dest != '0) begin
                ref_ready[s.alloc[l].dest] = 1'b0;
                ref_rob[s.alloc[l].dest] = s.alloc[l].rob_id;
            end
        end
    endtask

    task automatic compute_expected();
        prf_entry_t e;
        preg_idx_t  d;
        for (int r = 0; r < PREG_COUNT; r++) begin
            ref_value[r] = '0;
            ref_ready[r] = 1'b1;
            ref_rob[r] = '0;
        end
        for (int i = 0; i < n_steps; i++) begin
            for (int l = 0; l < LANES; l++) begin
                steps[i].exp_disp[0][l] = ref_read(steps[i].rd_idx[0][l], steps[i]);
                steps[i].exp_disp[1][l] = ref_read(steps[i].rd_idx[1][l], steps[i]);
                e = ref_read(steps[i].rd_idx[2][l], steps[i]);
                steps[i].exp_fu[0][l] = e.value;
                e = ref_read(steps[i].rd_idx[3][l], steps[i]);
                steps[i].exp_fu[1][l] = e.value;
                d = steps[i].cdb[l].dest;
                if (steps[i].cdb[l].valid && d != '0) begin
                    steps[i].exp_rob[l] = ref_rob[d];
                end else begin
                    steps[i].exp_rob[l] = '0;
                end
            end
            ref_update(steps[i]);
        end
    endtask

    task automatic apply_step(int i);
        for (int l = 0; l < LANES; l++) begin
            alloc[l] <= steps[i].alloc[l];
            cdb[l] <= steps[i].cdb[l];
            disp_rs1_idx[l] <= steps[i].rd_idx[0][l];
            disp_rs2_idx[l] <= steps[i].rd_idx[1][l];
            fu_rs1_idx[l] <= steps[i].rd_idx[2][l];
            fu_rs2_idx[l] <= steps[i].rd_idx[3][l];
        end
    endtask

    task automatic check_step(int i);
        string n;
        for (int l = 0; l < LANES; l++) begin
            n = step_names[i];
            check_value($sformatf("%s disp_rs1[%0d]", n, l),
                        64'(steps[i].exp_disp[0][l]), 64'(disp_rs1[l]));
            check_value($sformatf("%s disp_rs2[%0d]", n, l),
                        64'(steps[i].exp_disp[1][l]), 64'(disp_rs2[l]));
            check_value($sformatf("%s fu_rs1_val[%0d]", n, l),
                        64'(steps[i].exp_fu[0][l]), 64'(fu_rs1_val[l]));
            check_value($sformatf("%s fu_rs2_val[%0d]", n, l),
                        64'(steps[i].exp_fu[1][l]), 64'(fu_rs2_val[l]));
            check_value($sformatf("%s cdb_rob_id[%0d]", n, l),
                        64'(steps[i].exp_rob[l]), 64'(cdb_rob_id[l]));
        end
    endtask

    initial begin
        rst = 1'b1;
        for (int l = 0; l < LANES; l++) begin
            alloc[l] = '0;
            cdb[l] = '0;
            disp_rs1_idx[l] = '0;
            disp_rs2_idx[l] = '0;
            fu_rs1_idx[l] = '0;
            fu_rs2_idx[l] = '0;
        end

        build_directed();
        build_random();
        compute_expected();

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Outputs are sampled mid-cycle, well clear of the driving edge
        for (int i = 0; i < n_steps; i++) begin
            @(posedge clk);
            apply_step(i);
            @(negedge clk);
            check_step(i);
        end

        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : prf_tb

/* files.f */
src/prf_types_pkg.sv
src/cdb_pkg.sv
src/prf_entry_array.sv
src/prf_bypass_read.sv
src/prf_tag_lookup.sv
src/phys_reg_file.sv
dv/prf_props.sv
dv/prf_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the physical register file testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module prf_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

obj_dir/Vprf_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with no errors" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
